// ==== tb/axi_to_mem_cases.txt ====
# name kind(R/W) id(dec) addr(hex) len(dec) size(dec) data_base(hex) strb(hex)
# Consecutive lines with the same name are issued together as one test.
wr_single   W 3  0010 0 2 a5a50001 f
rd_single   R 5  0010 0 2 00000000 0
wr_burst    W 6  0040 3 2 12340000 f
rd_burst    R 7  0040 3 2 00000000 0
rd_halfword R 2  0102 3 1 00000000 0
wr_partial  W 9  0200 0 2 cafef00d 5
rd_partial  R 10 0200 0 2 00000000 0
mixed       R 11 0300 3 2 00000000 0
mixed       W 12 0380 3 2 77000000 f
mixed_long  R 1  0000 7 2 00000000 0
mixed_long  W 4  0080 5 2 5a000010 f
rd_mixed    R 13 0380 3 2 00000000 0

// ==== src.f ====
hdl/axi_proto_pkg.sv
hdl/mem_cfg_pkg.sv
hdl/burst_sequencer.sv
hdl/beat_buffer.sv
hdl/resp_composer.sv
hdl/axi_to_mem.sv
tb/axi_to_mem_assert.sv
tb/tb_axi_to_mem.sv

// ==== Bender.yml ====
package:
  name: axi_to_mem

sources:
  - hdl/axi_proto_pkg.sv
  - hdl/mem_cfg_pkg.sv
  - hdl/burst_sequencer.sv
  - hdl/beat_buffer.sv
  - hdl/resp_composer.sv
  - hdl/axi_to_mem.sv
  - target: test
    files:
      - tb/axi_to_mem_assert.sv
      - tb/tb_axi_to_mem.sv

// ==== tb/tb_axi_to_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axi_to_mem import axi_proto_pkg::*, mem_cfg_pkg::*; ();

  // Cycles any single wait may take.
  localparam int Timeout = 200;

  logic                 clk_i, rst_n_i;
  logic                 ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
  logic [IdWidth-1:0]   ar_id_i, aw_id_i, r_id_o, b_id_o;
  logic [AddrWidth-1:0] ar_addr_i, aw_addr_i, mem_addr_o;
  logic [LenWidth-1:0]  ar_len_i, aw_len_i;
  logic [SizeWidth-1:0] ar_size_i, aw_size_i;
  logic                 w_valid_i, w_ready_o, r_valid_o, r_last_o, r_ready_i;
  logic [DataWidth-1:0] w_data_i, r_data_o, mem_wdata_o, mem_rdata_i;
  logic [StrbWidth-1:0] w_strb_i, mem_strb_o;
  logic [RespWidth-1:0] r_resp_o, b_resp_o;
  logic                 b_valid_o, b_ready_i;
  logic                 mem_req_o, mem_gnt_i, mem_we_o, mem_rvalid_i;

  // Memory model and the expected memory image.
  logic [DataWidth-1:0] mem_q [256];
  logic [DataWidth-1:0] shadow [256];
  logic [DataWidth-1:0] resp_data [$];
  int unsigned          resp_due [$];
  int unsigned          cyc = 0;
  logic [15:0]          lfsr_q;
  logic                 gnt_delay;

  // Responses seen on R and B, and what each test expects.
  logic [DataWidth-1:0] r_got_data [$], exp_r_data [$];
  logic [IdWidth-1:0]   r_got_id [$], exp_r_id [$], b_got_id [$], exp_b_id [$];
  logic                 r_got_last [$], exp_r_last [$];
  logic [RespWidth-1:0] b_got_resp [$], r_got_resp [$];

  // Bursts read from the case file.
  string                c_name [$], c_kind [$];
  logic [IdWidth-1:0]   c_id [$];
  logic [AddrWidth-1:0] c_addr [$];
  int                   c_len [$], c_size [$];
  logic [DataWidth-1:0] c_base [$];
  logic [StrbWidth-1:0] c_strb [$];

  int errors = 0, test_errs = 0, tests_run = 0, tests_failed = 0;
  logic timed_out = 1'b0;

  axi_to_mem UUT (.*);

  // 16-bit Fibonacci LFSR, taps 16 14 13 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic take_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  // Power-on memory content, odd multiple of the word index.
  function automatic logic [DataWidth-1:0] fill_word(input int idx);
    return DataWidth'(idx) * 32'h9E37_79B1;
  endfunction

  // First beat as given, later beats from the aligned start.
  function automatic logic [AddrWidth-1:0] beat_addr(input logic [AddrWidth-1:0] start,
                                                     input int size, input int k);
    int unsigned bytes;
    int unsigned base;
    bytes = 1 << size;
    base  = (int'(start) / bytes) * bytes;
    if (k == 0) return start;
    return AddrWidth'(base + k * bytes);
  endfunction

  task automatic count_error();
    errors++;
    test_errs++;
  endtask

  task automatic check_r(input string name, input int beat,
                         input logic [DataWidth-1:0] exp_data, act_data,
                         input logic [IdWidth-1:0] exp_id, act_id,
                         input logic exp_last, act_last,
                         input logic [RespWidth-1:0] exp_resp, act_resp);
    if (act_data !== exp_data) begin
      $display("FAILED %s beat %0d r_data: expected %h, actual %h",
               name, beat, exp_data, act_data);
      count_error();
    end
    if (act_id !== exp_id) begin
      $display("FAILED %s beat %0d r_id: expected %0d, actual %0d", name, beat, exp_id, act_id);
      count_error();
    end
    if (act_last !== exp_last) begin
      $display("FAILED %s beat %0d r_last: expected %b, actual %b",
               name, beat, exp_last, act_last);
      count_error();
    end
    if (act_resp !== exp_resp) begin
      $display("FAILED %s beat %0d r_resp: expected %b, actual %b",
               name, beat, exp_resp, act_resp);
      count_error();
    end
  endtask

  task automatic check_b(input string name, input logic [IdWidth-1:0] exp_id, act_id,
                         input logic [RespWidth-1:0] exp_resp, act_resp);
    if (act_id !== exp_id) begin
      $display("FAILED %s b_id: expected %0d, actual %0d", name, exp_id, act_id);
      count_error();
    end
    if (act_resp !== exp_resp) begin
      $display("FAILED %s b_resp: expected %b, actual %b", name, exp_resp, act_resp);
      count_error();
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %-16s %0d mismatches", name, test_errs);
  endtask

  // Lines hold name, kind, id, addr, len, size, data base and strobe.
  task automatic load_cases();
    int          fd, rc, id, len, size;
    int unsigned addr, base, strb;
    string       line, nm, kd;
    fd = $fopen("tb/axi_to_mem_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/axi_to_mem_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 2 || line[0] == "#") continue;
      rc = $sscanf(line, "%s %s %d %h %d %d %h %h", nm, kd, id, addr, len, size, base, strb);
      if (rc != 8) begin
        $display("Case line could not be parsed: %s", line);
        errors++;
        continue;
      end
      c_name.push_back(nm);
      c_kind.push_back(kd);
      c_id.push_back(IdWidth'(id));
      c_addr.push_back(AddrWidth'(addr));
      c_len.push_back(len);
      c_size.push_back(size);
      c_base.push_back(DataWidth'(base));
      c_strb.push_back(StrbWidth'(strb));
    end
    $fclose(fd);
    if (c_name.size() == 0) begin
      $display("The case file holds no bursts");
      errors++;
    end
  endtask

  // Holds AR until the first read beat is granted.
  task automatic issue_read(input int idx);
    int   t;
    logic hs;
    ar_valid_i = 1'b1;
    ar_id_i    = c_id[idx];
    ar_addr_i  = c_addr[idx];
    ar_len_i   = LenWidth'(c_len[idx]);
    ar_size_i  = SizeWidth'(c_size[idx]);
    hs = 1'b0;
    t  = 0;
    while (!hs && t < Timeout) begin
      @(posedge clk_i);
      hs = ar_ready_o;
      @(negedge clk_i);
      t++;
    end
    ar_valid_i = 1'b0;
    if (!hs) begin
      $display("%s: AR channel stalled, no ready within %0d cycles", c_name[idx], Timeout);
      timed_out = 1'b1;
    end
  endtask

  // AW and W start together. Beat k carries base plus k.
  task automatic issue_write(input int idx);
    int   t, beat, aw_hs;
    logic got_aw, got_w;
    aw_valid_i = 1'b1;
    aw_id_i    = c_id[idx];
    aw_addr_i  = c_addr[idx];
    aw_len_i   = LenWidth'(c_len[idx]);
    aw_size_i  = SizeWidth'(c_size[idx]);
    w_valid_i  = 1'b1;
    w_data_i   = c_base[idx];
    w_strb_i   = c_strb[idx];
    beat  = 0;
    aw_hs = 0;
    t     = 0;
    while (beat <= c_len[idx] && t < Timeout) begin
      @(posedge clk_i);
      got_aw = aw_ready_o;
      got_w  = w_ready_o;
      @(negedge clk_i);
      t++;
      if (got_aw) begin
        aw_hs++;
        aw_valid_i = 1'b0;
      end
      if (got_w) begin
        beat++;
        t = 0;
        w_data_i = c_base[idx] + DataWidth'(beat);
      end
    end
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    if (beat <= c_len[idx]) begin
      $display("%s: W channel stalled at beat %0d", c_name[idx], beat);
      timed_out = 1'b1;
    end
    // One AW handshake per burst, taken with the first beat.
    if (aw_hs != 1) begin
      $display("FAILED %s AW handshakes: expected 1, actual %0d", c_name[idx], aw_hs);
      count_error();
    end
  endtask

  task automatic wait_responses(input string name);
    int t;
    t = 0;
    while ((r_got_data.size() < exp_r_data.size() || b_got_id.size() < exp_b_id.size())
           && t < Timeout) begin
      @(posedge clk_i);
      @(negedge clk_i);
      t++;
    end
    if (r_got_data.size() < exp_r_data.size()) begin
      $display("%s: R channel stalled after %0d beats", name, r_got_data.size());
      timed_out = 1'b1;
    end
    if (b_got_id.size() < exp_b_id.size()) begin
      $display("%s: B channel stalled, no write response", name);
      timed_out = 1'b1;
    end
    // A few idle cycles expose duplicated responses.
    repeat (5) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
  endtask

  // Lines first..stop-1 share one name and run at the same time.
  task automatic run_group(input int first, input int stop);
    int                   rd, wr, k;
    string                name;
    logic [AddrWidth-1:0] a;
    logic [DataWidth-1:0] d;
    name = c_name[first];
    rd = -1;
    wr = -1;
    test_errs = 0;
    exp_r_data.delete();
    exp_r_id.delete();
    exp_r_last.delete();
    exp_b_id.delete();
    r_got_data.delete();
    r_got_id.delete();
    r_got_last.delete();
    r_got_resp.delete();
    b_got_id.delete();
    b_got_resp.delete();
    for (k = first; k < stop; k++) begin
      if (c_kind[k] == "W") wr = k;
      else rd = k;
    end
    // A read returns the whole word that holds each beat address.
    if (rd >= 0) begin
      for (k = 0; k <= c_len[rd]; k++) begin
        a = beat_addr(c_addr[rd], c_size[rd], k);
        exp_r_data.push_back(shadow[a[9:2]]);
        exp_r_id.push_back(c_id[rd]);
        exp_r_last.push_back(k == c_len[rd]);
      end
    end
    if (wr >= 0) begin
      for (k = 0; k <= c_len[wr]; k++) begin
        a = beat_addr(c_addr[wr], c_size[wr], k);
        d = c_base[wr] + DataWidth'(k);
        for (int b = 0; b < StrbWidth; b++) begin
          if (c_strb[wr][b]) shadow[a[9:2]][8*b +: 8] = d[8*b +: 8];
        end
      end
      exp_b_id.push_back(c_id[wr]);
    end
    fork
      if (rd >= 0) issue_read(rd);
      if (wr >= 0) issue_write(wr);
    join
    if (!timed_out) wait_responses(name);
    for (k = 0; k < exp_r_data.size() && k < r_got_data.size(); k++) begin
      check_r(name, k, exp_r_data[k], r_got_data[k], exp_r_id[k], r_got_id[k],
              exp_r_last[k], r_got_last[k], RespOkay, r_got_resp[k]);
    end
    for (k = 0; k < exp_b_id.size() && k < b_got_id.size(); k++) begin
      check_b(name, exp_b_id[k], b_got_id[k], RespOkay, b_got_resp[k]);
    end
    if (r_got_data.size() != exp_r_data.size()) begin
      $display("FAILED %s R beat count: expected %0d, actual %0d",
               name, exp_r_data.size(), r_got_data.size());
      count_error();
    end
    if (b_got_id.size() != exp_b_id.size()) begin
      $display("FAILED %s B count: expected %0d, actual %0d",
               name, exp_b_id.size(), b_got_id.size());
      count_error();
    end
    report_test(name);
  endtask

  // Nothing may move while no burst is offered.
  task automatic check_idle();
    int k;
    test_errs = 0;
    for (k = 0; k < 10; k++) begin
      @(posedge clk_i);
      // Bits shown are mem_req, r_valid and b_valid.
      if (mem_req_o || r_valid_o || b_valid_o) begin
        $display("FAILED idle_after_reset cycle %0d: expected 000, actual %b%b%b",
                 k, mem_req_o, r_valid_o, b_valid_o);
        count_error();
      end
      @(negedge clk_i);
    end
    report_test("idle_after_reset");
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Memory side and R/B ready, all random bits drawn here.
  initial begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    r_ready_i    = 1'b0;
    b_ready_i    = 1'b0;
    gnt_delay    = 1'b0;
    lfsr_q       = 16'd13;
    for (int k = 0; k < 256; k++) mem_q[k] = fill_word(k);
    forever begin
      @(negedge clk_i);
      mem_gnt_i = take_bit() | take_bit();
      gnt_delay = take_bit();
      r_ready_i = take_bit();
      b_ready_i = take_bit();
      // Responses leave in grant order, one per cycle at most.
      if (resp_due.size() > 0 && resp_due[0] <= cyc + 1) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = resp_data.pop_front();
        void'(resp_due.pop_front());
      end else begin
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
      end
    end
  end

  // Grants, R beats and B responses happen on the rising edge.
  always @(posedge clk_i) begin
    logic [7:0] widx;
    cyc++;
    if (mem_req_o && mem_gnt_i) begin
      widx = mem_addr_o[9:2];
      if (mem_we_o) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (mem_strb_o[b]) mem_q[widx][8*b +: 8] = mem_wdata_o[8*b +: 8];
        end
      end
      resp_data.push_back(mem_q[widx]);
      resp_due.push_back(cyc + 1 + gnt_delay);
    end
    if (r_valid_o && r_ready_i) begin
      r_got_data.push_back(r_data_o);
      r_got_id.push_back(r_id_o);
      r_got_last.push_back(r_last_o);
      r_got_resp.push_back(r_resp_o);
    end
    if (b_valid_o && b_ready_i) begin
      b_got_id.push_back(b_id_o);
      b_got_resp.push_back(b_resp_o);
    end
  end

  initial begin
    int i, j;
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_size_i  = '0;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_size_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    for (int k = 0; k < 256; k++) shadow[k] = fill_word(k);
    load_cases();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_idle();
    i = 0;
    while (i < c_name.size() && !timed_out) begin
      j = i + 1;
      while (j < c_name.size() && c_name[j] == c_name[i]) j++;
      run_group(i, j);
      i = j;
    end
    $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
             tests_run, tests_failed, errors, UUT.u_axi_to_mem_assert.fail_cnt);
    if (errors == 0 && UUT.u_axi_to_mem_assert.fail_cnt == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/axi_to_mem_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_to_mem_assert import axi_proto_pkg::*, mem_cfg_pkg::*; (
  input wire logic                 clk_i,
  input wire logic                 rst_n_i,
  input wire logic                 r_valid_i,
  input wire logic                 r_ready_i,
  input wire logic [IdWidth-1:0]   r_id_i,
  input wire logic [DataWidth-1:0] r_data_i,
  input wire logic                 r_last_i,
  input wire logic                 b_valid_i,
  input wire logic                 b_ready_i,
  input wire logic [IdWidth-1:0]   b_id_i,
  input wire logic                 mem_req_i,
  input wire logic                 mem_gnt_i,
  input wire logic [AddrWidth-1:0] mem_addr_i,
  input wire logic                 mem_we_i,
  input wire logic                 pop_i
);

  // Failed assertions, read by the testbench at the end.
  int unsigned fail_cnt = 0;

  // Beats granted and not yet retired by the response side.
  int inflight;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight <= 0;
    end else begin
      inflight <= inflight + int'(mem_req_i && mem_gnt_i) - int'(pop_i);
    end
  end

  // A stalled R beat keeps its payload.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i && !r_ready_i |=>
      r_valid_i && $stable(r_id_i) && $stable(r_data_i) && $stable(r_last_i))
    else begin
      $error("R payload changed while R was stalled");
      fail_cnt++;
    end

  // Same for B.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_id_i))
    else begin
      $error("B payload changed while B was stalled");
      fail_cnt++;
    end

  // Pending memory request holds until granted.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i) && $stable(mem_we_i))
    else begin
      $error("Memory request changed before its grant");
      fail_cnt++;
    end

  // No request once MetaDepth beats wait in the buffer.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i |-> inflight < MetaDepth)
    else begin
      $error("Memory request raised without buffer space");
      fail_cnt++;
    end

endmodule

bind axi_to_mem axi_to_mem_assert u_axi_to_mem_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .r_valid_i  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_id_i     (r_id_o),
  .r_data_i   (r_data_o),
  .r_last_i   (r_last_o),
  .b_valid_i  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_id_i     (b_id_o),
  .mem_req_i  (mem_req_o),
  .mem_gnt_i  (mem_gnt_i),
  .mem_addr_i (mem_addr_o),
  .mem_we_i   (mem_we_o),
  .pop_i      (pop)
);

`default_nettype wire

// ==== hdl/axi_to_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_to_mem import axi_proto_pkg::*, mem_cfg_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 ar_valid_i,
  input  wire logic [IdWidth-1:0]   ar_id_i,
  input  wire logic [AddrWidth-1:0] ar_addr_i,
  input  wire logic [LenWidth-1:0]  ar_len_i,
  input  wire logic [SizeWidth-1:0] ar_size_i,
  output logic                      ar_ready_o,
  input  wire logic                 aw_valid_i,
  input  wire logic [IdWidth-1:0]   aw_id_i,
  input  wire logic [AddrWidth-1:0] aw_addr_i,
  input  wire logic [LenWidth-1:0]  aw_len_i,
  input  wire logic [SizeWidth-1:0] aw_size_i,
  output logic                      aw_ready_o,
  input  wire logic                 w_valid_i,
  input  wire logic [DataWidth-1:0] w_data_i,
  input  wire logic [StrbWidth-1:0] w_strb_i,
  output logic                      w_ready_o,
  output logic                      r_valid_o,
  output logic [IdWidth-1:0]        r_id_o,
  output logic [DataWidth-1:0]      r_data_o,
  output logic                      r_last_o,
  output logic [RespWidth-1:0]      r_resp_o,
  input  wire logic                 r_ready_i,
  output logic                      b_valid_o,
  output logic [IdWidth-1:0]        b_id_o,
  output logic [RespWidth-1:0]      b_resp_o,
  input  wire logic                 b_ready_i,
  output logic                      mem_req_o,
  input  wire logic                 mem_gnt_i,
  output logic [AddrWidth-1:0]      mem_addr_o,
  output logic [DataWidth-1:0]      mem_wdata_o,
  output logic [StrbWidth-1:0]      mem_strb_o,
  output logic                      mem_we_o,
  input  wire logic                 mem_rvalid_i,
  input  wire logic [DataWidth-1:0] mem_rdata_i
);

  // Sequencer to buffer.
  logic               space, push, push_last, push_write;
  logic [IdWidth-1:0] push_id;

  // Buffer to composer.
  logic                 head_valid, head_last, head_write, pop;
  logic [IdWidth-1:0]   head_id;
  logic [DataWidth-1:0] head_data;

  // Issues one memory request per beat.
  burst_sequencer u_burst_sequencer (
    .clk_i, .rst_n_i,
    .ar_valid_i, .ar_id_i, .ar_addr_i, .ar_len_i, .ar_size_i, .ar_ready_o,
    .aw_valid_i, .aw_id_i, .aw_addr_i, .aw_len_i, .aw_size_i, .aw_ready_o,
    .w_valid_i, .w_data_i, .w_strb_i, .w_ready_o,
    .mem_req_o, .mem_gnt_i, .mem_addr_o, .mem_wdata_o, .mem_strb_o, .mem_we_o,
    .space_i      (space),
    .push_o       (push),
    .push_id_o    (push_id),
    .push_last_o  (push_last),
    .push_write_o (push_write)
  );

  // Pairs beat metadata with memory responses.
  beat_buffer u_beat_buffer (
    .clk_i, .rst_n_i,
    .push_i       (push),
    .push_id_i    (push_id),
    .push_last_i  (push_last),
    .push_write_i (push_write),
    .space_o      (space),
    .mem_rvalid_i, .mem_rdata_i,
    .head_valid_o (head_valid),
    .head_id_o    (head_id),
    .head_last_o  (head_last),
    .head_write_o (head_write),
    .head_data_o  (head_data),
    .pop_i        (pop)
  );

  // Builds R beats and B responses.
  resp_composer u_resp_composer (
    .head_valid_i (head_valid),
    .head_id_i    (head_id),
    .head_last_i  (head_last),
    .head_write_i (head_write),
    .head_data_i  (head_data),
    .pop_o        (pop),
    .r_valid_o, .r_id_o, .r_data_o, .r_last_o, .r_resp_o, .r_ready_i,
    .b_valid_o, .b_id_o, .b_resp_o, .b_ready_i
  );

endmodule

`default_nettype wire

// ==== hdl/resp_composer.sv ====
`timescale 1ns/1ns
`default_nettype none

module resp_composer import axi_proto_pkg::*, mem_cfg_pkg::*; (
  input  wire logic                 head_valid_i,
  input  wire logic [IdWidth-1:0]   head_id_i,
  input  wire logic                 head_last_i,
  input  wire logic                 head_write_i,
  input  wire logic [DataWidth-1:0] head_data_i,
  output logic                      pop_o,
  output logic                      r_valid_o,
  output logic [IdWidth-1:0]        r_id_o,
  output logic [DataWidth-1:0]      r_data_o,
  output logic                      r_last_o,
  output logic [RespWidth-1:0]      r_resp_o,
  input  wire logic                 r_ready_i,
  output logic                      b_valid_o,
  output logic [IdWidth-1:0]        b_id_o,
  output logic [RespWidth-1:0]      b_resp_o,
  input  wire logic                 b_ready_i
);

  // Write beats before the last one carry no response.
  logic silent_beat;

  assign silent_beat = head_valid_i & head_write_i & ~head_last_i;

  // Reads go to R, the closing write beat goes to B.
  assign r_valid_o = head_valid_i & ~head_write_i;
  assign b_valid_o = head_valid_i & head_write_i & head_last_i;

  // Retire on the handshake of the chosen channel.
  assign pop_o = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i) | silent_beat;

  // R payload.
  assign r_id_o   = head_id_i;
  assign r_data_o = head_data_i;
  assign r_last_o = head_last_i;
  assign r_resp_o = RespOkay;

  // B payload.
  assign b_id_o   = head_id_i;
  assign b_resp_o = RespOkay;

endmodule

`default_nettype wire

// ==== hdl/beat_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module beat_buffer import axi_proto_pkg::*, mem_cfg_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 push_i,
  input  wire logic [IdWidth-1:0]   push_id_i,
  input  wire logic                 push_last_i,
  input  wire logic                 push_write_i,
  output logic                      space_o,
  input  wire logic                 mem_rvalid_i,
  input  wire logic [DataWidth-1:0] mem_rdata_i,
  output logic                      head_valid_o,
  output logic [IdWidth-1:0]        head_id_o,
  output logic                      head_last_o,
  output logic                      head_write_o,
  output logic [DataWidth-1:0]      head_data_o,
  input  wire logic                 pop_i
);

  // Metadata queue storage.
  logic [IdWidth-1:0]   meta_id_mem [MetaDepth];
  logic                 meta_last_mem [MetaDepth];
  logic                 meta_write_mem [MetaDepth];
  logic [PtrWidth-1:0]  meta_wptr, meta_rptr;
  logic [CntWidth-1:0]  meta_cnt;
  logic                 meta_empty;

  // Read data queue storage.
  logic [DataWidth-1:0] data_mem [MetaDepth];
  logic [PtrWidth-1:0]  data_wptr, data_rptr;
  logic [CntWidth-1:0]  data_cnt;
  logic                 data_empty;

  // Pointers wrap at MetaDepth, which need not be a power of two.
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(MetaDepth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  assign meta_empty = (meta_cnt == '0);
  assign data_empty = (data_cnt == '0);
  assign space_o    = (meta_cnt != CntWidth'(MetaDepth));

  // Empty queues pass their input straight to the head.
  assign head_valid_o = (!meta_empty || push_i) && (!data_empty || mem_rvalid_i);
  assign head_id_o    = meta_empty ? push_id_i : meta_id_mem[meta_rptr];
  assign head_last_o  = meta_empty ? push_last_i : meta_last_mem[meta_rptr];
  assign head_write_o = meta_empty ? push_write_i : meta_write_mem[meta_rptr];
  assign head_data_o  = data_empty ? mem_rdata_i : data_mem[data_rptr];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_wptr <= '0;
      meta_rptr <= '0;
      meta_cnt  <= '0;
      data_wptr <= '0;
      data_rptr <= '0;
      data_cnt  <= '0;
    end else begin
      if (push_i) begin
        meta_wptr <= ptr_next(meta_wptr);
      end
      if (mem_rvalid_i) begin
        data_wptr <= ptr_next(data_wptr);
      end
      // Both queues retire together.
      if (pop_i) begin
        meta_rptr <= ptr_next(meta_rptr);
        data_rptr <= ptr_next(data_rptr);
      end
      meta_cnt <= meta_cnt + CntWidth'(push_i) - CntWidth'(pop_i);
      data_cnt <= data_cnt + CntWidth'(mem_rvalid_i) - CntWidth'(pop_i);
    end
  end

  // Entries are written even when they fall through; the read pointer skips them.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      meta_id_mem[meta_wptr]    <= push_id_i;
      meta_last_mem[meta_wptr]  <= push_last_i;
      meta_write_mem[meta_wptr] <= push_write_i;
    end
    if (mem_rvalid_i) begin
      data_mem[data_wptr] <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/burst_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_sequencer import axi_proto_pkg::*, mem_cfg_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 ar_valid_i,
  input  wire logic [IdWidth-1:0]   ar_id_i,
  input  wire logic [AddrWidth-1:0] ar_addr_i,
  input  wire logic [LenWidth-1:0]  ar_len_i,
  input  wire logic [SizeWidth-1:0] ar_size_i,
  output logic                      ar_ready_o,
  input  wire logic                 aw_valid_i,
  input  wire logic [IdWidth-1:0]   aw_id_i,
  input  wire logic [AddrWidth-1:0] aw_addr_i,
  input  wire logic [LenWidth-1:0]  aw_len_i,
  input  wire logic [SizeWidth-1:0] aw_size_i,
  output logic                      aw_ready_o,
  input  wire logic                 w_valid_i,
  input  wire logic [DataWidth-1:0] w_data_i,
  input  wire logic [StrbWidth-1:0] w_strb_i,
  output logic                      w_ready_o,
  output logic                      mem_req_o,
  input  wire logic                 mem_gnt_i,
  output logic [AddrWidth-1:0]      mem_addr_o,
  output logic [DataWidth-1:0]      mem_wdata_o,
  output logic [StrbWidth-1:0]      mem_strb_o,
  output logic                      mem_we_o,
  input  wire logic                 space_i,
  output logic                      push_o,
  output logic [IdWidth-1:0]        push_id_o,
  output logic                      push_last_o,
  output logic                      push_write_o
);

  // Burst state, one set per direction.
  logic [LenWidth-1:0]  r_cnt_q, w_cnt_q;
  logic [AddrWidth-1:0] r_addr_q, w_addr_q;
  logic [SizeWidth-1:0] r_size_q, w_size_q;
  logic [IdWidth-1:0]   r_id_q, w_id_q;
  logic                 r_busy, w_busy;

  // Beat offered by each direction.
  logic                 rd_valid, wr_valid;
  logic [AddrWidth-1:0] rd_addr, wr_addr;
  logic [IdWidth-1:0]   rd_id, wr_id;
  logic                 rd_last, wr_last;

  // Arbiter state. sel high picks the write side.
  logic sel, sel_q, lock_q;
  logic req_valid, grant, rd_gnt, wr_gnt;

  // Align to the beat size, then step one beat forward.
  function automatic logic [AddrWidth-1:0] next_addr(input logic [AddrWidth-1:0] addr,
                                                     input logic [SizeWidth-1:0] size);
    logic [AddrWidth-1:0] step;
    step = AddrWidth'(1) << size;
    return (addr & ~(step - AddrWidth'(1))) + step;
  endfunction

  assign r_busy = (r_cnt_q != '0);
  assign w_busy = (w_cnt_q != '0);

  // Read beat. A new burst uses its address unaligned.
  always_comb begin
    rd_valid = 1'b0;
    rd_addr  = ar_addr_i;
    rd_id    = ar_id_i;
    rd_last  = (ar_len_i == '0);
    if (r_busy) begin
      rd_valid = 1'b1;
      rd_addr  = next_addr(r_addr_q, r_size_q);
      rd_id    = r_id_q;
      rd_last  = (r_cnt_q == LenWidth'(1));
    end else if (ar_valid_i) begin
      rd_valid = 1'b1;
    end
  end

  // Write beat, offered only with W data present.
  always_comb begin
    wr_valid = 1'b0;
    wr_addr  = aw_addr_i;
    wr_id    = aw_id_i;
    wr_last  = (aw_len_i == '0);
    if (w_busy) begin
      wr_valid = w_valid_i;
      wr_addr  = next_addr(w_addr_q, w_size_q);
      wr_id    = w_id_q;
      wr_last  = (w_cnt_q == LenWidth'(1));
    end else if (aw_valid_i && w_valid_i) begin
      wr_valid = 1'b1;
    end
  end

  // Arbitration. A locked choice holds until its grant.
  always_comb begin
    sel = sel_q;
    if (!lock_q) begin
      if (wr_valid ^ rd_valid) begin
        sel = wr_valid;
      end else if (wr_valid && rd_valid) begin
        // Last write beat beats a read burst in flight.
        if (wr_last && !rd_last) begin
          sel = 1'b1;
        // Ongoing bursts go first.
        end else if (w_busy) begin
          sel = 1'b1;
        end else if (r_busy) begin
          sel = 1'b0;
        end else begin
          sel = ~sel_q;
        end
      end
    end
  end

  assign req_valid = sel ? wr_valid : rd_valid;
  assign mem_req_o = req_valid & space_i;
  assign grant     = mem_req_o & mem_gnt_i;
  assign rd_gnt    = grant & ~sel;
  assign wr_gnt    = grant & sel;

  // Memory request payload.
  assign mem_addr_o  = sel ? wr_addr : rd_addr;
  assign mem_wdata_o = w_data_i;
  assign mem_strb_o  = w_strb_i;
  assign mem_we_o    = sel;

  // Address channels accept on the first granted beat.
  assign ar_ready_o = rd_gnt & ~r_busy;
  assign aw_ready_o = wr_gnt & ~w_busy;
  assign w_ready_o  = wr_gnt;

  // Metadata for the beat buffer.
  assign push_o       = grant;
  assign push_id_o    = sel ? wr_id : rd_id;
  assign push_last_o  = sel ? wr_last : rd_last;
  assign push_write_o = sel;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_cnt_q <= '0;
      w_cnt_q <= '0;
      sel_q   <= 1'b0;
      lock_q  <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= mem_req_o & ~mem_gnt_i;
      if (rd_gnt) begin
        r_cnt_q <= r_busy ? r_cnt_q - LenWidth'(1) : ar_len_i;
      end
      if (wr_gnt) begin
        w_cnt_q <= w_busy ? w_cnt_q - LenWidth'(1) : aw_len_i;
      end
    end
  end

  // Beat address, size and id of each burst.
  always_ff @(posedge clk_i) begin
    if (rd_gnt) begin
      r_addr_q <= rd_addr;
      if (!r_busy) begin
        r_size_q <= ar_size_i;
        r_id_q   <= ar_id_i;
      end
    end
    if (wr_gnt) begin
      w_addr_q <= wr_addr;
      if (!w_busy) begin
        w_size_q <= aw_size_i;
        w_id_q   <= aw_id_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

  // Byte address and word width of the memory port.
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  // One strobe bit per data byte.
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Outstanding memory requests, and the queue depth that covers them.
  localparam int unsigned BufDepth  = 2;
  localparam int unsigned MetaDepth = BufDepth + 1;

  // Queue pointer and fill count widths.
  localparam int unsigned PtrWidth = $clog2(MetaDepth);
  localparam int unsigned CntWidth = $clog2(MetaDepth + 1);

endpackage

`default_nettype wire

// ==== hdl/axi_proto_pkg.sv ====
`default_nettype none

package axi_proto_pkg;

  // Transaction ID width.
  localparam int unsigned IdWidth = 4;

  // Burst length field. A burst has len plus one beats.
  localparam int unsigned LenWidth = 8;

  // Beat size field, encoded as the log2 of the byte count.
  localparam int unsigned SizeWidth = 3;

  // Response field width.
  localparam int unsigned RespWidth = 2;

  // OKAY is the only response this slave gives.
  localparam logic [RespWidth-1:0] RespOkay = 2'b00;

endpackage

`default_nettype wire
